//--- hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

  localparam int addr_width  = 24;  // byte address
  localparam int word_width  = 32;  // host word
  localparam int line_width  = 64;  // lower memory line
  localparam int offset_bits = 3;   // byte offset within a line
  localparam int num_ways    = 4;
  localparam int count_bits  = 3;   // saturating usage counter
  localparam int state_bits  = 2;

  localparam int words_per_line = line_width / word_width;

  // line state codes, invalid must stay all zero so reset clears to it
  localparam logic [state_bits-1:0] ls_invalid = 2'd0;
  localparam logic [state_bits-1:0] ls_clean   = 2'd1;
  localparam logic [state_bits-1:0] ls_dirty   = 2'd2;

  // one cache line, seen whole by the lower memory or as words by the host
  typedef union packed {
    logic [line_width-1:0] line;
    logic [words_per_line-1:0][word_width-1:0] words;  // words[0] is the low half
  } line_u;

endpackage

`default_nettype wire

//--- hdl/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way #(
  parameter int index_bits = 14
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [cache_pkg::addr_width-1:0]      addr_hig,
  input  logic                                  line_wr,
  input  logic                                  count_inc,
  input  logic                                  count_clr,
  input  cache_pkg::line_u                      wr_line,
  input  logic [cache_pkg::state_bits-1:0]      wr_state,
  output logic                                  hit,
  output cache_pkg::line_u                      line,
  output logic [cache_pkg::addr_width-index_bits-cache_pkg::offset_bits-1:0] tag,
  output logic [cache_pkg::state_bits-1:0]      state,
  output logic [cache_pkg::count_bits-1:0]      use_count
);

  import cache_pkg::*;

  localparam int tag_bits = addr_width - index_bits - offset_bits;
  localparam int num_sets = 1 << index_bits;

  line_u                 data_mem  [num_sets];
  logic [tag_bits-1:0]   tag_mem   [num_sets];
  logic [state_bits-1:0] state_mem [num_sets];
  logic [count_bits-1:0] count_mem [num_sets];

  logic [index_bits-1:0] index;
  logic [tag_bits-1:0]   addr_tag;

  assign index    = addr_hig[offset_bits +: index_bits];
  assign addr_tag = addr_hig[addr_width-1 -: tag_bits];

  // lookup at the current host address
  assign line      = data_mem[index];
  assign tag       = tag_mem[index];
  assign state     = state_mem[index];
  assign use_count = count_mem[index];
  assign hit       = (tag_mem[index] == addr_tag) && (state_mem[index] != ls_invalid);

  always_ff @(posedge clk) begin
    if (line_wr) begin
      data_mem[index] <= wr_line;
      tag_mem[index]  <= addr_tag;  // unchanged on a hit, new tag on a fill
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        state_mem[s] <= ls_invalid;
        count_mem[s] <= '0;
      end
    end else begin
      if (line_wr) begin
        state_mem[index] <= wr_state;
      end
      if (count_clr) begin
        count_mem[index] <= '0;
      end else if (count_inc && (count_mem[index] != '1)) begin
        count_mem[index] <= count_mem[index] + 1'b1;  // saturates at max
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/victim_select.sv
`timescale 1ns/1ps
`default_nettype none

module victim_select (
  input  logic [cache_pkg::num_ways-1:0][cache_pkg::state_bits-1:0] states,
  input  logic [cache_pkg::num_ways-1:0][cache_pkg::count_bits-1:0] counts,
  output logic [1:0]                                                victim_way
);

  import cache_pkg::*;

  logic                  any_invalid;
  logic [1:0]            first_invalid;
  logic                  com1;
  logic                  com2;
  logic [count_bits-1:0] min1;
  logic [count_bits-1:0] min2;

  always_comb begin
    any_invalid   = 1'b0;
    first_invalid = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (states[w] == ls_invalid) begin
        any_invalid   = 1'b1;
        first_invalid = 2'(w);  // lowest index wins
      end
    end
  end

  // pairwise minimum, the lower way keeps a tie
  assign com1 = counts[0] > counts[1];
  assign min1 = com1 ? counts[1] : counts[0];
  assign com2 = counts[2] > counts[3];
  assign min2 = com2 ? counts[3] : counts[2];

  always_comb begin
    if (any_invalid) begin
      victim_way = first_invalid;
    end else if (min1 > min2) begin
      victim_way = {1'b1, com2};
    end else begin
      victim_way = {1'b0, com1};
    end
  end

endmodule

`default_nettype wire

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
  parameter int index_bits = 14
) (
  input  logic                                                      clk,
  input  logic                                                      reset,
  input  logic                                                      ce_hig,
  input  logic                                                      rw_hig,
  input  logic [cache_pkg::addr_width-1:0]                          addr_hig,
  input  logic [cache_pkg::word_width-1:0]                          wdata_hig,
  input  logic [cache_pkg::num_ways-1:0]                            way_hit,
  input  cache_pkg::line_u [cache_pkg::num_ways-1:0]                way_lines,
  input  logic [cache_pkg::num_ways-1:0]
               [cache_pkg::addr_width-index_bits-cache_pkg::offset_bits-1:0] way_tags,
  input  logic [cache_pkg::num_ways-1:0][cache_pkg::state_bits-1:0] way_states,
  input  logic [1:0]                                                victim_way,
  input  logic [cache_pkg::line_width-1:0]                          rdata_low,
  input  logic                                                      rdy_low,
  output logic                                                      rdy_hig,
  output logic [cache_pkg::word_width-1:0]                          rdata_hig,
  output logic [cache_pkg::num_ways-1:0]                            line_wr,
  output logic [cache_pkg::num_ways-1:0]                            count_inc,
  output logic [cache_pkg::num_ways-1:0]                            count_clr,
  output cache_pkg::line_u                                          wr_line,
  output logic [cache_pkg::state_bits-1:0]                          wr_state,
  output logic                                                      ce_low,
  output logic                                                      rw_low,
  output logic [cache_pkg::addr_width-1:0]                          addr_low,
  output logic [cache_pkg::line_width-1:0]                          wdata_low
);

  import cache_pkg::*;

  localparam logic [1:0] st_idle       = 2'd0;
  localparam logic [1:0] st_write_back = 2'd1;
  localparam logic [1:0] st_fill       = 2'd2;
  localparam logic [1:0] st_respond    = 2'd3;

  logic [1:0]            state;
  logic [1:0]            vic;      // way being replaced
  logic [1:0]            hit_way;
  logic [1:0]            acc_way;
  logic                  word_sel;
  logic [index_bits-1:0] index;
  logic                  req;
  logic                  hit_go;
  logic                  miss_go;
  logic                  victim_dirty;
  logic                  fill_go;
  logic                  fill_done;
  line_u                 fill_line;

  assign index        = addr_hig[offset_bits +: index_bits];
  assign word_sel     = addr_hig[offset_bits-1];
  assign fill_line    = rdata_low;
  assign acc_way      = (state == st_respond) ? vic : hit_way;
  assign victim_dirty = way_states[victim_way] == ls_dirty;

  // ce_hig is not looked at while rdy_hig is up
  assign req       = (state == st_idle) && ce_hig && !rdy_hig;
  assign hit_go    = req && (|way_hit);
  assign miss_go   = req && !(|way_hit);
  assign fill_go   = (miss_go && !victim_dirty) || ((state == st_fill) && !ce_low);
  assign fill_done = (state == st_fill) && ce_low && rdy_low;

  always_comb begin
    hit_way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_way = 2'(w);
      end
    end
  end

  // way update: word merge on host writes, whole line on a fill
  always_comb begin
    line_wr   = '0;
    count_inc = '0;
    count_clr = '0;
    wr_line   = way_lines[acc_way];
    wr_line.words[word_sel] = wdata_hig;
    wr_state  = ls_dirty;
    if (hit_go) begin
      line_wr[hit_way]   = !rw_hig;
      count_inc[hit_way] = 1'b1;
    end else if (fill_done) begin
      line_wr[vic]   = 1'b1;
      count_clr[vic] = 1'b1;
      wr_line        = fill_line;
      wr_state       = ls_clean;
    end else if (state == st_respond) begin
      line_wr[vic]   = !rw_hig;  // access on the freshly filled line
      count_inc[vic] = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= st_idle;
      vic     <= '0;
      rdy_hig <= 1'b0;
      ce_low  <= 1'b0;
      rw_low  <= 1'b1;
    end else begin
      rdy_hig <= hit_go || fill_done;
      case (state)
        st_idle: begin
          if (miss_go) begin
            vic    <= victim_way;
            ce_low <= 1'b1;
            rw_low <= !victim_dirty;  // write back first if dirty
            state  <= victim_dirty ? st_write_back : st_fill;
          end
        end
        st_write_back: begin
          if (rdy_low) begin
            ce_low <= 1'b0;
            state  <= st_fill;
          end
        end
        st_fill: begin
          if (fill_go) begin
            ce_low <= 1'b1;
            rw_low <= 1'b1;
          end else if (rdy_low) begin
            ce_low <= 1'b0;
            state  <= st_respond;
          end
        end
        default: begin
          state <= st_idle;  // respond lasts one cycle
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (hit_go && rw_hig) begin
      rdata_hig <= way_lines[hit_way].words[word_sel];
    end else if (fill_done && rw_hig) begin
      rdata_hig <= fill_line.words[word_sel];
    end
    if (miss_go && victim_dirty) begin
      addr_low  <= {way_tags[victim_way], index, {offset_bits{1'b0}}};
      wdata_low <= way_lines[victim_way].line;
    end else if (fill_go) begin
      addr_low <= {addr_hig[addr_width-1:offset_bits], {offset_bits{1'b0}}};
    end
  end

endmodule

`default_nettype wire

//--- hdl/cache_l2.sv
`timescale 1ns/1ps
`default_nettype none

module cache_l2 #(
  parameter int index_bits = 14
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [cache_pkg::addr_width-1:0]   addr_hig,
  input  logic [cache_pkg::word_width-1:0]   wdata_hig,
  input  logic                               rw_hig,
  input  logic                               ce_hig,
  output logic                               rdy_hig,
  output logic [cache_pkg::word_width-1:0]   rdata_hig,
  output logic [cache_pkg::addr_width-1:0]   addr_low,
  output logic [cache_pkg::line_width-1:0]   wdata_low,
  input  logic [cache_pkg::line_width-1:0]   rdata_low,
  output logic                               rw_low,
  output logic                               ce_low,
  input  logic                               rdy_low
);

  import cache_pkg::*;

  localparam int tag_bits = addr_width - index_bits - offset_bits;

  logic [num_ways-1:0]                 way_hit;
  line_u [num_ways-1:0]                way_lines;
  logic [num_ways-1:0][tag_bits-1:0]   way_tags;
  logic [num_ways-1:0][state_bits-1:0] way_states;
  logic [num_ways-1:0][count_bits-1:0] way_counts;
  logic [num_ways-1:0]                 line_wr;
  logic [num_ways-1:0]                 count_inc;
  logic [num_ways-1:0]                 count_clr;
  line_u                               wr_line;
  logic [state_bits-1:0]               wr_state;
  logic [1:0]                          victim_way;

  for (genvar g = 0; g < num_ways; g++) begin : gen_way
    cache_way #(
      .index_bits(index_bits)
    ) way_inst (
      .clk       (clk),
      .reset     (reset),
      .addr_hig  (addr_hig),
      .line_wr   (line_wr[g]),
      .count_inc (count_inc[g]),
      .count_clr (count_clr[g]),
      .wr_line   (wr_line),
      .wr_state  (wr_state),
      .hit       (way_hit[g]),
      .line      (way_lines[g]),
      .tag       (way_tags[g]),
      .state     (way_states[g]),
      .use_count (way_counts[g])
    );
  end

  victim_select victim_inst (
    .states     (way_states),
    .counts     (way_counts),
    .victim_way (victim_way)
  );

  cache_ctrl #(
    .index_bits(index_bits)
  ) ctrl_inst (
    .clk        (clk),
    .reset      (reset),
    .ce_hig     (ce_hig),
    .rw_hig     (rw_hig),
    .addr_hig   (addr_hig),
    .wdata_hig  (wdata_hig),
    .way_hit    (way_hit),
    .way_lines  (way_lines),
    .way_tags   (way_tags),
    .way_states (way_states),
    .victim_way (victim_way),
    .rdata_low  (rdata_low),
    .rdy_low    (rdy_low),
    .rdy_hig    (rdy_hig),
    .rdata_hig  (rdata_hig),
    .line_wr    (line_wr),
    .count_inc  (count_inc),
    .count_clr  (count_clr),
    .wr_line    (wr_line),
    .wr_state   (wr_state),
    .ce_low     (ce_low),
    .rw_low     (rw_low),
    .addr_low   (addr_low),
    .wdata_low  (wdata_low)
  );

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;  // released away from the active edge
  end

  always #4 clk = ~clk;  // 8 ns period

endmodule

`default_nettype wire

//--- verification/cache_l2_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cache_l2_chk (
  input logic                             clk,
  input logic                             reset,
  input logic                             ce_hig,
  input logic                             rdy_hig,
  input logic                             ce_low,
  input logic                             rw_low,
  input logic                             rdy_low,
  input logic [cache_pkg::addr_width-1:0] addr_low
);

  rdy_one_cycle: assert property (@(posedge clk) disable iff (reset)
      rdy_hig |=> !rdy_hig)
    else $error("rdy_hig held for more than one cycle");

  // host may drop ce_hig during the response cycle, so look one edge back
  rdy_needs_request: assert property (@(posedge clk) disable iff (reset)
      rdy_hig |-> $past(ce_hig))
    else $error("rdy_hig raised without a host request");

  low_request_stable: assert property (@(posedge clk) disable iff (reset)
      ce_low && !rdy_low |=> $stable(addr_low) && $stable(rw_low))
    else $error("addr_low or rw_low changed while waiting for rdy_low");

  quiet_after_reset: assert property (@(posedge clk)
      reset |=> !rdy_hig && !ce_low)
    else $error("rdy_hig or ce_low high after reset");

endmodule

bind cache_l2 cache_l2_chk chk_inst (
  .clk      (clk),
  .reset    (reset),
  .ce_hig   (ce_hig),
  .rdy_hig  (rdy_hig),
  .ce_low   (ce_low),
  .rw_low   (rw_low),
  .rdy_low  (rdy_low),
  .addr_low (addr_low)
);

`default_nettype wire

//--- verification/cache_l2_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_l2_tb;

  import cache_pkg::*;

  localparam int index_bits = 4;
  localparam int max_pats   = 64;
  localparam int fields     = 5;  // op, address, write data, read data, lower count

  logic                  clk;
  logic                  reset;
  logic [addr_width-1:0] addr_hig;
  logic [word_width-1:0] wdata_hig;
  logic                  rw_hig;
  logic                  ce_hig;
  logic                  rdy_hig;
  logic [word_width-1:0] rdata_hig;
  logic [addr_width-1:0] addr_low;
  logic [line_width-1:0] wdata_low;
  logic [line_width-1:0] rdata_low;
  logic                  rw_low;
  logic                  ce_low;
  logic                  rdy_low;

  logic [31:0]           pats [0:max_pats*fields-1];
  logic [line_width-1:0] mem_lines [int];  // lines written back, keyed by line address
  logic [word_width-1:0] host_words [int];  // words the host wrote, keyed by word address
  int                    num_pats;
  int                    watch_cycles;
  int                    errors;
  int                    checks;
  int                    n_reads;
  int                    n_writes;
  int                    mem_delay;
  logic                  wb_late;
  logic [31:0]           wb_addr;
  logic [line_width-1:0] wb_data;
  logic [31:0]           fill_addr;
  int unsigned           seed;

  tb_clock clock_inst (
    .clk   (clk),
    .reset (reset)
  );

  cache_l2 #(
    .index_bits(index_bits)
  ) cache_l2_inst (
    .clk       (clk),
    .reset     (reset),
    .addr_hig  (addr_hig),
    .wdata_hig (wdata_hig),
    .rw_hig    (rw_hig),
    .ce_hig    (ce_hig),
    .rdy_hig   (rdy_hig),
    .rdata_hig (rdata_hig),
    .addr_low  (addr_low),
    .wdata_low (wdata_low),
    .rdata_low (rdata_low),
    .rw_low    (rw_low),
    .ce_low    (ce_low),
    .rdy_low   (rdy_low)
  );

  function automatic logic [word_width-1:0] init_word(input logic [addr_width-1:0] a);
    return {8'h5A, a};
  endfunction

  function automatic logic [line_width-1:0] read_line(input logic [addr_width-1:0] a);
    if (mem_lines.exists(int'(a))) begin
      return mem_lines[int'(a)];
    end
    return {init_word(a + 24'd4), init_word(a)};  // word 0 in the low half
  endfunction

  // latest host value of a word, as the lower memory must hold it after a write-back
  function automatic logic [word_width-1:0] expected_word(input logic [addr_width-1:0] a);
    if (host_words.exists(int'(a))) begin
      return host_words[int'(a)];
    end
    return init_word(a);
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // lower memory answers each request after mem_delay falling edges
  always begin
    @(negedge clk);
    if (ce_low === 1'b1) begin
      repeat (mem_delay) @(negedge clk);
      if (rw_low) begin
        rdata_low = read_line(addr_low);
        fill_addr = 32'(addr_low);
        n_reads++;
      end else begin
        mem_lines[int'(addr_low)] = wdata_low;
        wb_addr  = 32'(addr_low);
        wb_data  = wdata_low;
        wb_late  = wb_late || (n_reads != 0);
        n_writes++;
      end
      rdy_low = 1'b1;
      @(negedge clk);
      rdy_low = 1'b0;
    end
  end

  task automatic run_access(input int n);
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic [31:0] exp_txn;
    logic [31:0] line_addr;
    int          gap;
    int          errs_before;
    op        = pats[n*fields];
    addr      = pats[n*fields+1];
    wdata     = pats[n*fields+2];
    exp_data  = pats[n*fields+3];
    exp_txn   = pats[n*fields+4];
    line_addr = {addr[31:offset_bits], {offset_bits{1'b0}}};
    gap       = $urandom_range(0, 3);
    mem_delay = $urandom_range(0, 2);
    repeat (gap + 1) @(negedge clk);  // address held through the last response cycle
    n_reads     = 0;
    n_writes    = 0;
    wb_late     = 1'b0;
    errs_before = errors;
    ce_hig      = 1'b1;
    rw_hig      = op[0];
    addr_hig    = addr[addr_width-1:0];
    wdata_hig   = wdata;
    do begin
      @(negedge clk);
    end while (rdy_hig !== 1'b1);
    ce_hig = 1'b0;
    if (op[0]) begin
      check_value(rdata_hig, exp_data, "read data");
    end
    check_value(n_reads + n_writes, exp_txn, "lower transaction count");
    check_value(n_reads, (exp_txn != 0) ? 1 : 0, "lower reads");
    if (n_reads != 0) begin
      check_value(fill_addr, line_addr, "fill address");
    end
    if (n_writes != 0) begin
      check_value(wb_late, 1'b0, "write-back came after the fill read");
      check_value(wb_addr[offset_bits +: index_bits], addr[offset_bits +: index_bits],
                  "write-back set");
      check_value(wb_addr[offset_bits-1:0], 0, "write-back alignment");
      check_value(wb_addr == line_addr, 0, "write-back hit the requested line");
      check_value(wb_data[word_width-1:0], expected_word(wb_addr[addr_width-1:0]),
                  "write-back word 0");
      check_value(wb_data[line_width-1:word_width],
                  expected_word(wb_addr[addr_width-1:0] + 24'd4), "write-back word 1");
    end
    if (!op[0]) begin
      host_words[int'({addr[addr_width-1:2], 2'b00})] = wdata;
    end
    $display("test %0d: %s %h, lower reads %0d, lower writes %0d, %s", n,
             op[0] ? "read " : "write", addr[addr_width-1:0], n_reads, n_writes,
             (errors == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin : watchdog
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge clk);
    $display("timeout: the accesses did not finish within %0d cycles", watch_cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : main
    seed      = 32'h4a8f911f;
    void'($urandom(seed));
    ce_hig    = 1'b0;
    rw_hig    = 1'b1;
    addr_hig  = '0;
    wdata_hig = '0;
    rdata_low = '0;
    rdy_low   = 1'b0;
    mem_delay = 0;
    errors    = 0;
    checks    = 0;
    $readmemh("verification/cache_patterns.txt", pats);
    while (num_pats < max_pats && pats[num_pats*fields] !== 32'bx) begin
      num_pats++;
    end
    watch_cycles = num_pats * 200;
    if (num_pats == 0) begin
      $display("no access patterns were read from the patterns file");
    end
    wait (reset === 1'b0);
    for (int i = 0; i < num_pats; i++) begin
      run_access(i);
    end
    $display("%0d tests, %0d checks, %0d errors", num_pats, checks, errors);
    if (errors == 0 && num_pats > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/cache_patterns.txt
// op (1 read, 0 write), byte address, write data, expected read data, lower transactions
// all hex; with 4 index bits, addresses 0x80 apart share a set
1 000008 00000000 5A000008 1
1 000008 00000000 5A000008 0
0 00000C 11112222 00000000 0
1 00000C 00000000 11112222 0
1 000008 00000000 5A000008 0
0 000014 33334444 00000000 1
1 000014 00000000 33334444 0
1 000010 00000000 5A000010 0
// set 0, counts decide the victim, dirty lines written back
1 000000 00000000 5A000000 1
1 000080 00000000 5A000080 1
0 000104 55556666 00000000 1
1 000180 00000000 5A000180 1
1 000000 00000000 5A000000 0
1 000004 00000000 5A000004 0
1 000080 00000000 5A000080 0
1 000184 00000000 5A000184 0
1 000200 00000000 5A000200 2
1 000104 00000000 55556666 1
1 000100 00000000 5A000100 0
1 000280 00000000 5A000280 1
1 000080 00000000 5A000080 1
1 000000 00000000 5A000000 0
0 000180 77778888 00000000 0
1 000084 00000000 5A000084 0
1 000080 00000000 5A000080 0
1 000084 00000000 5A000084 0
1 000104 00000000 55556666 0
1 000100 00000000 5A000100 0
1 000300 00000000 5A000300 2
1 000180 00000000 77778888 1
1 000184 00000000 5A000184 0
// set 3, write misses with dirty victims
0 000018 AAAA0001 00000000 1
0 000098 AAAA0002 00000000 1
0 00011C AAAA0003 00000000 1
0 00019C AAAA0004 00000000 1
1 000098 00000000 AAAA0002 0
1 000118 00000000 5A000118 0
1 00019C 00000000 AAAA0004 0
0 00021C BBBB0005 00000000 2
1 000018 00000000 AAAA0001 2
1 00001C 00000000 5A00001C 0
1 00021C 00000000 BBBB0005 1

//--- filelist.f
hdl/cache_pkg.sv
hdl/cache_way.sv
hdl/victim_select.sv
hdl/cache_ctrl.sv
hdl/cache_l2.sv
verification/tb_clock.sv
verification/cache_l2_chk.sv
verification/cache_l2_tb.sv

//--- Bender.yml
package:
  name: cache_l2

sources:
  - hdl/cache_pkg.sv
  - hdl/cache_way.sv
  - hdl/victim_select.sv
  - hdl/cache_ctrl.sv
  - hdl/cache_l2.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/cache_l2_chk.sv
      - verification/cache_l2_tb.sv
